//--- common/zuart_pkg.sv
package zuart_pkg;

    //////////////////////////////////////////////////////////////////////
    // link timing.
    //////////////////////////////////////////////////////////////////////
    localparam int CLKS_PER_BIT    = 16;    // clock cycles per serial bit.
    localparam int FRAME_PERIOD    = 2000;  // cycles between frame ticks.
    localparam int UART_FRAME_BITS = 10;    // start, 8 data, stop.

    localparam int DIV_W    = $clog2(CLKS_PER_BIT);  // bit divisor width.
    localparam int PERIOD_W = $clog2(FRAME_PERIOD);  // tick counter width.

    //////////////////////////////////////////////////////////////////////
    // frame layout.
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] SYNC0 = 8'h55;  // first sync byte.
    localparam logic [7:0] SYNC1 = 8'hAA;  // second sync byte.

    localparam int SYNC_BYTES    = 2;
    localparam int PAYLOAD_BYTES = 4;
    localparam int FRAME_BYTES   = SYNC_BYTES + PAYLOAD_BYTES + 1;  // plus checksum.

    localparam int IDX_W     = $clog2(FRAME_BYTES);    // byte index in frame.
    localparam int PAY_CNT_W = $clog2(PAYLOAD_BYTES);  // payload byte index.

    // eight hex digits, d7 in the top nibble.
    typedef struct packed {
        logic [3:0] d7;
        logic [3:0] d6;
        logic [3:0] d5;
        logic [3:0] d4;
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } digit_word_t;

    // one received byte plus the sampled stop level.
    typedef struct packed {
        logic [7:0] data;
        logic       stop_ok;
    } rx_byte_t;

    // payload byte k of a digit word, high digit in the high nibble.
    function automatic logic [7:0] payload_byte(digit_word_t w, logic [PAY_CNT_W-1:0] k);
        case (k)
            2'd0:    return {w.d7, w.d6};
            2'd1:    return {w.d5, w.d4};
            2'd2:    return {w.d3, w.d2};
            default: return {w.d1, w.d0};
        endcase
    endfunction

endpackage

//--- hw/uart/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_pin,
    output logic       tx_done
);
    import zuart_pkg::*;

    logic             busy;     // frame on the line.
    logic [DIV_W-1:0] div_cnt;  // cycle within current bit.
    logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop.
    logic [8:0]       shreg;    // remaining data bits, stop bit on top.
    logic             bit_end;  // last cycle of a bit.
    logic             last_bit; // stop bit in progress.

    assign bit_end  = (div_cnt == DIV_W'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_cnt == 4'(UART_FRAME_BITS - 1));

    // last cycle of the stop bit.
    assign tx_done = busy && bit_end && last_bit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            tx_pin  <= 1'b1;  // line idles high.
        end else if (!busy) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            if (tx_start) begin
                busy   <= 1'b1;
                tx_pin <= 1'b0;  // start bit from the next cycle.
            end
        end else if (bit_end) begin
            div_cnt <= '0;
            if (last_bit) begin
                busy <= 1'b0;  // stop bit already high, line stays idle.
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
                tx_pin  <= shreg[0];  // lsb first.
            end
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // shift register, loaded on accept and shifted per bit.
    always_ff @(posedge clk) begin
        if (!busy && tx_start) begin
            shreg <= {1'b1, tx_byte};
        end else if (busy && bit_end && !last_bit) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

//--- hw/uart/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx_pin,
    output logic               rx_strobe,
    output zuart_pkg::rx_byte_t rx_byte
);
    import zuart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;   // first sync flop.
    logic             rx_sync;   // second sync flop.
    logic             rx_prev;   // for edge detect.
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;   // data bit index.
    logic [7:0]       shreg;     // data, filled from the top.
    logic             half_bit;  // middle of the start bit.
    logic             full_bit;  // middle of a data or stop bit.
    logic             fall;

    assign half_bit = (div_cnt == DIV_W'(CLKS_PER_BIT / 2 - 1));
    assign full_bit = (div_cnt == DIV_W'(CLKS_PER_BIT - 1));
    assign fall     = rx_prev && !rx_sync;

    //////////////////////////////////////////////////////////////////////
    // input synchronizer.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bit timing FSM.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            div_cnt   <= div_cnt + DIV_W'(1);
            case (state)
                RX_IDLE: begin
                    div_cnt <= '0;
                    if (fall) state <= RX_START;
                end
                RX_START: if (half_bit) begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch if high again.
                end
                RX_DATA: if (full_bit) begin
                    div_cnt <= '0;
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                default: if (full_bit) begin
                    rx_strobe <= 1'b1;  // report even a bad stop.
                    state     <= RX_IDLE;
                end
            endcase
        end
    end

    // data path, sampled at bit centers.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && full_bit) begin
            shreg <= {rx_sync, shreg[7:1]};  // lsb arrives first.
        end
        if (state == RX_STOP && full_bit) begin
            rx_byte <= '{data: shreg, stop_ok: rx_sync};
        end
    end

endmodule

//--- hw/frame_tx_sequencer.sv
`timescale 1ns/100ps

module frame_tx_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  zuart_pkg::digit_word_t digits,
    input  logic                   tx_done,
    output logic                   tx_start,
    output logic [7:0]             tx_byte
);
    import zuart_pkg::*;

    logic [PERIOD_W-1:0] period_cnt;
    logic                tick;        // one cycle every FRAME_PERIOD.
    logic                busy;        // frame in progress.
    logic                frame_go;    // first byte of a new frame.
    logic                next_go;     // following byte, cycle after tx_done.
    logic [IDX_W-1:0]    byte_idx;    // byte now on the line.
    logic                is_payload;
    digit_word_t         snap;        // digits frozen at frame start.
    logic [7:0]          csum;        // running payload sum.

    assign tick     = (period_cnt == PERIOD_W'(FRAME_PERIOD - 1));
    assign frame_go = tick && en && !busy;  // ticks mid-frame are dropped.
    assign tx_start = frame_go || next_go;

    assign is_payload = (byte_idx >= IDX_W'(SYNC_BYTES)) &&
                        (byte_idx <  IDX_W'(SYNC_BYTES + PAYLOAD_BYTES));

    //////////////////////////////////////////////////////////////////////
    // byte select.
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (byte_idx == IDX_W'(0)) begin
            tx_byte = SYNC0;
        end else if (byte_idx == IDX_W'(1)) begin
            tx_byte = SYNC1;
        end else if (is_payload) begin
            tx_byte = payload_byte(snap, PAY_CNT_W'(byte_idx - IDX_W'(SYNC_BYTES)));
        end else begin
            tx_byte = csum;  // last byte of the frame.
        end
    end

    //////////////////////////////////////////////////////////////////////
    // period counter and sequencing.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            busy       <= 1'b0;
            next_go    <= 1'b0;
            byte_idx   <= '0;
            csum       <= '0;
        end else begin
            period_cnt <= tick ? '0 : period_cnt + PERIOD_W'(1);  // free running.
            next_go    <= 1'b0;
            if (frame_go) begin
                busy     <= 1'b1;
                byte_idx <= '0;
                csum     <= '0;
            end else begin
                if (busy && tx_done) begin
                    if (byte_idx == IDX_W'(FRAME_BYTES - 1)) begin
                        busy     <= 1'b0;  // frame complete, en not checked.
                        byte_idx <= '0;
                    end else begin
                        byte_idx <= byte_idx + IDX_W'(1);
                        next_go  <= 1'b1;
                    end
                end
                // sum each payload byte as it is issued.
                if (next_go && is_payload) csum <= csum + tx_byte;
            end
        end
    end

    // snapshot keeps the frame consistent if digits move.
    always_ff @(posedge clk) begin
        if (frame_go) snap <= digits;
    end

endmodule

//--- hw/frame_rx_parser.sv
`timescale 1ns/100ps

module frame_rx_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx_strobe,
    input  zuart_pkg::rx_byte_t    rx_byte,
    output zuart_pkg::digit_word_t rx_digits,
    output logic                   rx_valid,
    output logic                   rx_error
);
    import zuart_pkg::*;

    typedef enum logic [1:0] {
        P_HUNT,     // waiting for SYNC0.
        P_SYNC1,    // SYNC0 seen.
        P_PAYLOAD,  // collecting digits.
        P_CHECK     // checksum byte next.
    } parse_state_t;

    parse_state_t         state;
    logic [PAY_CNT_W-1:0] pay_cnt;  // payload bytes taken.
    logic [7:0]           sum;      // running payload sum.
    logic [31:0]          payload;  // first byte ends up on top.
    logic                 last_pay;

    assign last_pay = (pay_cnt == PAY_CNT_W'(PAYLOAD_BYTES - 1));

    //////////////////////////////////////////////////////////////////////
    // frame FSM.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= P_HUNT;
            pay_cnt   <= '0;
            sum       <= '0;
            rx_digits <= '0;
            rx_valid  <= 1'b0;
            rx_error  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    P_HUNT: begin
                        // a broken SYNC0 is just noise here.
                        if (rx_byte.stop_ok && rx_byte.data == SYNC0) state <= P_SYNC1;
                    end
                    P_SYNC1: begin
                        pay_cnt <= '0;
                        sum     <= '0;
                        if (!rx_byte.stop_ok) begin
                            rx_error <= 1'b1;
                            state    <= P_HUNT;
                        end else if (rx_byte.data == SYNC1) begin
                            state <= P_PAYLOAD;
                        end else if (rx_byte.data != SYNC0) begin
                            state <= P_HUNT;  // repeated 0x55 keeps waiting.
                        end
                    end
                    P_PAYLOAD: begin
                        if (!rx_byte.stop_ok) begin
                            rx_error <= 1'b1;
                            state    <= P_HUNT;
                        end else begin
                            sum     <= sum + rx_byte.data;
                            pay_cnt <= pay_cnt + PAY_CNT_W'(1);
                            if (last_pay) state <= P_CHECK;
                        end
                    end
                    default: begin
                        if (rx_byte.stop_ok && rx_byte.data == sum) begin
                            rx_valid  <= 1'b1;
                            rx_digits <= digit_word_t'(payload);  // held until next good frame.
                        end else begin
                            rx_error <= 1'b1;
                        end
                        state <= P_HUNT;
                    end
                endcase
            end
        end
    end

    // payload shift, d7/d6 shifted in first.
    always_ff @(posedge clk) begin
        if (rx_strobe && state == P_PAYLOAD) payload <= {payload[23:0], rx_byte.data};
    end

endmodule

//--- hw/zuart_link_top.sv
`timescale 1ns/100ps

module zuart_link_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  zuart_pkg::digit_word_t digits,
    input  logic                   rx_pin,
    output logic                   tx_pin,
    output zuart_pkg::digit_word_t rx_digits,
    output logic                   rx_valid,
    output logic                   rx_error
);
    import zuart_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // transmit path.
    //////////////////////////////////////////////////////////////////////
    logic       tx_start;  // one cycle, only while uart_tx idle.
    logic [7:0] tx_byte;
    logic       tx_done;   // end of stop bit.

    frame_tx_sequencer i_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .digits   (digits),
        .tx_done  (tx_done),
        .tx_start (tx_start),
        .tx_byte  (tx_byte)
    );

    uart_tx i_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_pin   (tx_pin),
        .tx_done  (tx_done)
    );

    //////////////////////////////////////////////////////////////////////
    // receive path, rx_pin independent of tx_pin.
    //////////////////////////////////////////////////////////////////////
    logic     rx_strobe;  // no back-pressure.
    rx_byte_t rx_byte;

    uart_rx i_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_pin    (rx_pin),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

    frame_rx_parser i_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte),
        .rx_digits (rx_digits),
        .rx_valid  (rx_valid),
        .rx_error  (rx_error)
    );

endmodule

//--- test/tb_zuart_link.sv
`timescale 1ns/100ps

module tb_zuart_link;
    import zuart_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        en;
    digit_word_t digits;
    logic        loop_sel;  // 1 loops tx_pin back to rx_pin.
    logic        inj_pin;   // serial injector line.
    logic        rx_line;
    logic        tx_pin;
    digit_word_t rx_digits;
    logic        rx_valid;
    logic        rx_error;

    logic [15:0] lfsr_state;
    int          valid_cnt = 0;
    int          error_cnt = 0;
    digit_word_t got_digits;      // rx_digits seen with the last rx_valid.
    logic [31:0] expect_q[$];     // model snapshots, one per sent frame.

    assign rx_line = loop_sel ? tx_pin : inj_pin;

    zuart_link_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .digits    (digits),
        .rx_pin    (rx_line),
        .tx_pin    (tx_pin),
        .rx_digits (rx_digits),
        .rx_valid  (rx_valid),
        .rx_error  (rx_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    // count reports at the falling edge.
    always @(negedge clk) begin
        if (rx_valid) begin
            valid_cnt  = valid_cnt + 1;
            got_digits = rx_digits;
        end
        if (rx_error) error_cnt = error_cnt + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // random source and frame model.
    //////////////////////////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 16'hB400;  // taps 16 14 13 11.
        return n;
    endfunction

    task automatic rand_word(output logic [31:0] w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            w          = {w[30:0], lfsr_state[0]};  // one step per bit.
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // sum of the four nibble-pair bytes modulo 256.
    function automatic logic [7:0] model_sum(input logic [31:0] w);
        logic [7:0] s;
        int         k;
        s = 8'h00;
        for (k = 0; k < PAYLOAD_BYTES; k++) s = s + w[8*k +: 8];
        return s;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] w, input int k);
        if (k == 0) return SYNC0;
        else if (k == 1) return SYNC1;
        else if (k < 2 + PAYLOAD_BYTES) return w[31 - 8 * (k - 2) -: 8];  // d7/d6 first.
        else return model_sum(w);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and waits.
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1, "wait timed out");
    endtask

    // wait until the valid or error count passes base.
    task automatic wait_report(input bit on_error, input int base, input string what);
        int n;
        n = 0;
        while (((on_error ? error_cnt : valid_cnt) <= base) && (n < 3 * FRAME_PERIOD)) begin
            @(negedge clk);
            n++;
        end
        if ((on_error ? error_cnt : valid_cnt) <= base) stop_on_timeout(what);
    endtask

    task automatic wait_tx_fall(input string what);
        int n;
        n = 0;
        while ((tx_pin !== 1'b0) && (n < 3 * FRAME_PERIOD)) begin
            @(negedge clk);
            n++;
        end
        if (tx_pin !== 1'b0) stop_on_timeout(what);
    endtask

    // samples one byte off tx_pin at bit centers.
    task automatic capture_tx_byte(output logic [7:0] data, output logic start_lvl,
                                   output logic stop_lvl);
        int i;
        wait_tx_fall("a start bit on tx_pin");
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // middle of start bit.
        start_lvl = tx_pin;
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx_pin;  // lsb first.
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        stop_lvl = tx_pin;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers.
    //////////////////////////////////////////////////////////////////////
    task automatic new_digits();
        logic [31:0] w;
        rand_word(w);
        @(posedge clk);
        #2;
        digits = w;
    endtask

    task automatic drive_bit(input logic v);
        @(posedge clk);
        #2;
        inj_pin = v;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // start, 8 data, chosen stop level, then two idle bits.
    task automatic send_byte(input logic [7:0] data, input logic stop_lvl);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) drive_bit(data[i]);
        drive_bit(stop_lvl);
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    // bad_idx picks the byte with a low stop bit or is -1.
    task automatic send_frame(input logic [31:0] w, input logic [7:0] csum, input int bad_idx);
        int k;
        for (k = 0; k < FRAME_BYTES - 1; k++) send_byte(model_byte(w, k), k != bad_idx);
        send_byte(csum, bad_idx != FRAME_BYTES - 1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // scenarios.
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] w;
        logic [31:0] prev;
        logic [7:0]  b;
        logic        start_lvl;
        logic        stop_lvl;
        int          base_v;
        int          base_e;
        int          k;

        lfsr_state = 16'd57583;
        rst_n      = 1'b0;
        en         = 1'b0;
        digits     = '0;
        loop_sel   = 1'b1;
        inj_pin    = 1'b1;  // idle line.
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // loopback frame.
        new_digits();
        en     = 1'b1;
        base_v = valid_cnt;
        base_e = error_cnt;
        wait_report(1'b0, base_v, "rx_valid of the first loopback frame");
        check_value("loopback digits", digits, got_digits);
        check_value("loopback rx_error count", base_e, error_cnt);

        // wire format of the next frame off tx_pin.
        new_digits();
        base_v = valid_cnt;
        for (k = 0; k < FRAME_BYTES; k++) begin
            capture_tx_byte(b, start_lvl, stop_lvl);
            check_value($sformatf("wire byte %0d", k), model_byte(digits, k), b);
            check_value($sformatf("wire start %0d", k), 1'b0, start_lvl);
            check_value($sformatf("wire stop %0d", k), 1'b1, stop_lvl);
        end
        wait_report(1'b0, base_v, "rx_valid after the wire capture");
        check_value("wire frame digits", digits, got_digits);

        // enable gating over three periods.
        @(posedge clk);
        #2;
        en     = 1'b0;
        base_v = valid_cnt;
        repeat (3 * FRAME_PERIOD) begin
            @(negedge clk);
            check_value("gated tx_pin", 1'b1, tx_pin);
        end
        check_value("gated rx_valid count", base_v, valid_cnt);
        new_digits();
        en = 1'b1;
        wait_report(1'b0, base_v, "rx_valid after enable returns");
        check_value("re-enabled digits", digits, got_digits);

        // injected bad checksum.
        @(posedge clk);
        #2;
        en       = 1'b0;
        loop_sel = 1'b0;  // both lines high here.
        prev     = digits;  // last frame the model sent.
        base_v   = valid_cnt;
        base_e   = error_cnt;
        rand_word(w);
        send_frame(w, model_sum(w) + 8'd1, -1);
        wait_report(1'b1, base_e, "rx_error on a bad checksum");
        check_value("bad checksum error count", base_e + 1, error_cnt);
        check_value("bad checksum valid count", base_v, valid_cnt);
        check_value("rx_digits held", prev, rx_digits);
        rand_word(w);
        send_frame(w, model_sum(w), -1);
        wait_report(1'b0, base_v, "rx_valid after a bad checksum");
        check_value("good frame after bad checksum", w, got_digits);

        // low stop bit on the last payload byte, stray sync, then a good frame.
        base_v = valid_cnt;
        base_e = error_cnt;
        rand_word(w);
        send_frame(w, model_sum(w), SYNC_BYTES + PAYLOAD_BYTES - 1);
        send_byte(SYNC0, 1'b1);
        rand_word(w);
        send_frame(w, model_sum(w), -1);
        wait_report(1'b0, base_v, "rx_valid after the stop bit error");
        check_value("stop bit error count", base_e + 1, error_cnt);
        check_value("stop bit valid count", base_v + 1, valid_cnt);
        check_value("resync digits", w, got_digits);

        // twenty loopback frames with digits moved mid-frame.
        @(posedge clk);
        #2;
        loop_sel = 1'b1;  // tx idle since en went low.
        en       = 1'b1;
        base_e   = error_cnt;
        for (k = 0; k < 20; k++) begin
            base_v = valid_cnt;
            wait_tx_fall("the start of a frame on tx_pin");
            expect_q.push_back(digits);  // what the tick froze.
            new_digits();
            wait_report(1'b0, base_v, "rx_valid in the frame run");
            check_value($sformatf("frame %0d digits", k), expect_q.pop_front(), got_digits);
        end
        check_value("frame run error count", base_e, error_cnt);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- project.f
common/zuart_pkg.sv
hw/uart/uart_tx.sv
hw/uart/uart_rx.sv
hw/frame_tx_sequencer.sv
hw/frame_rx_parser.sv
hw/zuart_link_top.sv
test/tb_zuart_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the zuart link testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_zuart_link \
    -f project.f

# The simulator's exit status is not used; the log decides.
./obj_dir/Vtb_zuart_link > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"
